// File: list.f
+incdir+src
src/bus_pkg.sv
src/serial_pkg.sv
src/bit_timer.sv
src/periph_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/spi_tx.sv
src/serial_periph.sv
verification/tb_serial_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
        -f list.f \
        --top-module tb_serial_periph \
        -o tb_serial_periph

./obj_dir/tb_serial_periph | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi

// File: src/bit_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module bit_timer #(
        parameter int DIV = `UART_BIT_DIV       // Clocks per period
) (
        input  logic    clk,
        input  logic    RSTn,
        input  logic    run,
        output logic    tick,
        output logic    mid
);

        localparam int CW = `TIMER_W;
        localparam logic [CW-1:0] LAST = CW'(DIV - 1);
        localparam logic [CW-1:0] HALF = CW'(DIV / 2 - 1);     // DIV/2 clocks after restart

        logic [CW-1:0] cnt;

        // Held at zero while idle, so a rising run restarts the period
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        cnt <= '0;
                else if (!run || cnt == LAST)
                        cnt <= '0;      // Idle or wrap
                else
                        cnt <= cnt + 1'b1;
        end

        assign tick = run && (cnt == LAST);     // End of period
        assign mid  = run && (cnt == HALF);     // Middle of period

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none
`include "periph_defs.svh"

package bus_pkg;

        // Master side of a Wishbone classic access
        typedef struct packed {
                logic                   cyc;
                logic                   stb;
                logic                   we;
                logic [`WB_ADR_W-1:0]   adr;    // Register select
                logic [`WB_DAT_W-1:0]   dat_w;
        } wb_req_t;

        // Slave answer, ack is a single cycle
        typedef struct packed {
                logic                   ack;
                logic [`WB_DAT_W-1:0]   dat_r;  // Valid with ack
        } wb_rsp_t;

endpackage

`default_nettype wire

// File: src/periph_defs.svh
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define WB_ADR_W        2       // Word address, four registers
`define WB_DAT_W        32

// ----------------------------------------
// Serial widths and dividers
// ----------------------------------------
`define UART_DATA_W     8       // One character
`define SPI_DATA_W      24      // Tuner control word
`define UART_BIT_DIV    16      // Clocks per UART bit
`define SPI_HALF_DIV    2       // Clocks per sclk half period
`define TIMER_W         8       // Bit timer counter width

// ----------------------------------------
// Register map
// ----------------------------------------
`define REG_UART_DATA   0
`define REG_UART_STAT   1
`define REG_SPI_DATA    2
`define REG_SPI_STAT    3

`endif

// File: src/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module periph_regs
        import bus_pkg::*, serial_pkg::*;
(
        input  logic                            clk,
        input  logic                            RSTn,
        input  wb_req_t                         wb_req,
        output wb_rsp_t                         wb_rsp,
        input  serial_status_t                  status,
        input  logic                            rx_done,
        input  logic [`UART_DATA_W-1:0]         rx_byte,
        output logic                            tx_start,
        output logic [`UART_DATA_W-1:0]         tx_byte,
        output logic                            spi_start,
        output logic [`SPI_DATA_W-1:0]          spi_word,
        output logic                            rx_valid
);

        logic                   ack_q;
        logic [`WB_DAT_W-1:0]   dat_r_q;
        logic [`WB_DAT_W-1:0]   rd_data;
        logic [`UART_DATA_W-1:0] rx_buf;        // Last good byte
        logic                   acc;            // New access this cycle
        logic                   wr_acc;
        logic                   rd_acc;
        periph_reg_e            reg_sel;

        // ----------------------------------------
        // Bus handshake
        // ----------------------------------------
        assign acc     = wb_req.cyc & wb_req.stb & ~ack_q;     // Held request is acked once
        assign wr_acc  = acc & wb_req.we;
        assign rd_acc  = acc & ~wb_req.we;
        assign reg_sel = periph_reg_e'(wb_req.adr);

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        ack_q <= 1'b0;
                else
                        ack_q <= acc;
        end

        always_comb begin
                rd_data = '0;   // Upper bits read zero
                case (reg_sel)
                        REG_UART_DATA: rd_data[`UART_DATA_W-1:0] = rx_buf;
                        REG_UART_STAT: rd_data[1:0] = {status.rx_valid, status.tx_busy};
                        REG_SPI_STAT:  rd_data[0] = status.spi_busy;
                        default:       rd_data = '0;    // SPI word is write only
                endcase
        end

        always_ff @(posedge clk) begin
                if (rd_acc)
                        dat_r_q <= rd_data;
        end

        assign wb_rsp.ack   = ack_q;
        assign wb_rsp.dat_r = dat_r_q;

        // ----------------------------------------
        // Start pulses, dropped while busy
        // ----------------------------------------
        assign tx_start  = wr_acc && (reg_sel == REG_UART_DATA) && !status.tx_busy;
        assign tx_byte   = wb_req.dat_w[`UART_DATA_W-1:0];
        assign spi_start = wr_acc && (reg_sel == REG_SPI_DATA) && !status.spi_busy;
        assign spi_word  = wb_req.dat_w[`SPI_DATA_W-1:0];

        // Receive buffer, new byte wins over a clearing read
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        rx_valid <= 1'b0;
                else if (rx_done)
                        rx_valid <= 1'b1;
                else if (rd_acc && (reg_sel == REG_UART_DATA))
                        rx_valid <= 1'b0;
        end

        always_ff @(posedge clk) begin
                if (rx_done)
                        rx_buf <= rx_byte;      // Overwrites an unread byte
        end

        a_ack_single: assert property (@(posedge clk) disable iff (!RSTn)
                wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

// File: src/serial_periph.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module serial_periph
        import bus_pkg::*, serial_pkg::*;
(
        input  logic    clk,
        input  logic    RSTn,
        input  wb_req_t wb_req,
        output wb_rsp_t wb_rsp,
        input  logic    rxd,
        output logic    txd,
        output logic    irq,
        output logic    spi_cs,
        output logic    spi_sclk,
        output logic    spi_sdata
);

        serial_status_t                 status;
        logic                           tx_start;
        logic [`UART_DATA_W-1:0]        tx_byte;
        logic                           tx_busy;
        logic                           rx_done;
        logic [`UART_DATA_W-1:0]        rx_byte;
        logic                           rx_valid;
        logic                           spi_start;
        logic [`SPI_DATA_W-1:0]         spi_word;
        logic                           spi_busy;

        assign status = '{tx_busy: tx_busy, rx_valid: rx_valid, spi_busy: spi_busy};
        assign irq    = rx_valid;   // Unread byte pending

        periph_regs i_periph_regs (
                .clk (clk), .RSTn (RSTn), .wb_req (wb_req), .wb_rsp (wb_rsp),
                .status (status), .rx_done (rx_done), .rx_byte (rx_byte),
                .tx_start (tx_start), .tx_byte (tx_byte),
                .spi_start (spi_start), .spi_word (spi_word), .rx_valid (rx_valid)
        );

        uart_tx i_uart_tx (
                .clk (clk), .RSTn (RSTn), .start (tx_start), .data (tx_byte),
                .txd (txd), .busy (tx_busy)
        );

        uart_rx i_uart_rx (
                .clk (clk), .RSTn (RSTn), .rxd (rxd), .done (rx_done), .data (rx_byte)
        );

        // Tuner programming port
        spi_tx i_spi_tx (
                .clk (clk), .RSTn (RSTn), .start (spi_start), .data (spi_word),
                .cs (spi_cs), .sclk (spi_sclk), .sdata (spi_sdata), .busy (spi_busy)
        );

endmodule

`default_nettype wire

// File: src/serial_pkg.sv
`default_nettype none
`include "periph_defs.svh"

package serial_pkg;

        // Shared by UART transmitter and receiver
        typedef enum logic [1:0] {
                UART_IDLE,
                UART_START,
                UART_DATA,
                UART_STOP
        } uart_state_e;

        typedef enum logic [1:0] {
                SPI_IDLE,
                SPI_SHIFT,      // Toggling sclk
                SPI_DONE        // One cycle before cs rises
        } spi_state_e;

        // Register map as decoded on the bus
        typedef enum logic [`WB_ADR_W-1:0] {
                REG_UART_DATA   = `REG_UART_DATA,
                REG_UART_STAT   = `REG_UART_STAT,
                REG_SPI_DATA    = `REG_SPI_DATA,
                REG_SPI_STAT    = `REG_SPI_STAT
        } periph_reg_e;

        typedef struct packed {
                logic   tx_busy;
                logic   rx_valid;
                logic   spi_busy;
        } serial_status_t;

endpackage

`default_nettype wire

// File: src/spi_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module spi_tx
        import serial_pkg::*;
(
        input  logic                            clk,
        input  logic                            RSTn,
        input  logic                            start,
        input  logic [`SPI_DATA_W-1:0]          data,
        output logic                            cs,
        output logic                            sclk,
        output logic                            sdata,
        output logic                            busy
);

        localparam int EW = $clog2(`SPI_DATA_W + 1);

        spi_state_e             state;
        logic [`SPI_DATA_W-1:0] shreg;          // MSB on the line
        logic [EW-1:0]          edge_cnt;       // Rising edges so far
        logic                   tick;

        bit_timer #(.DIV(`SPI_HALF_DIV)) i_bit_timer (
                .clk    (clk),
                .RSTn   (RSTn),
                .run    (state == SPI_SHIFT),
                .tick   (tick),                 // One per half period
                .mid    ()
        );

        assign busy = (state != SPI_IDLE);

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state    <= SPI_IDLE;
                        cs       <= 1'b1;
                        sclk     <= 1'b0;
                        sdata    <= 1'b0;
                        edge_cnt <= '0;
                end else begin
                        case (state)
                        SPI_IDLE: if (start) begin
                                state    <= SPI_SHIFT;
                                cs       <= 1'b0;
                                sdata    <= data[`SPI_DATA_W-1];
                                edge_cnt <= '0;
                        end
                        SPI_SHIFT: if (tick) begin
                                sclk <= ~sclk;
                                if (!sclk)
                                        edge_cnt <= edge_cnt + 1'b1;    // Rising edge
                                else if (edge_cnt == EW'(`SPI_DATA_W))
                                        state <= SPI_DONE;              // Last falling edge
                                else
                                        sdata <= shreg[`SPI_DATA_W-2];  // Change while sclk low
                        end
                        default: begin
                                state <= SPI_IDLE;
                                cs    <= 1'b1;
                                sdata <= 1'b0;
                        end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (state == SPI_IDLE && start)
                        shreg <= data;
                else if (state == SPI_SHIFT && tick && sclk)
                        shreg <= shreg << 1;    // Next bit on falling edge
        end

        a_sclk_idle: assert property (@(posedge clk) disable iff (!RSTn)
                cs |-> !sclk);

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module uart_rx
        import serial_pkg::*;
(
        input  logic                            clk,
        input  logic                            RSTn,
        input  logic                            rxd,
        output logic                            done,
        output logic [`UART_DATA_W-1:0]         data
);

        localparam int BW = $clog2(`UART_DATA_W);

        uart_state_e    state;
        logic [2:0]     sync;           // Two stage sync plus previous value
        logic           rx;
        logic           fall;
        logic           run;
        logic           mid;
        logic [BW-1:0]  bit_cnt;

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        sync <= '1;
                else
                        sync <= {sync[1:0], rxd};
        end

        assign rx   = sync[1];
        assign fall = sync[2] & ~sync[1];
        assign run  = (state != UART_IDLE);

        bit_timer #(.DIV(`UART_BIT_DIV)) i_bit_timer (
                .clk    (clk),
                .RSTn   (RSTn),
                .run    (run),
                .tick   (),
                .mid    (mid)   // All samples taken mid bit
        );

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state   <= UART_IDLE;
                        bit_cnt <= '0;
                        done    <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        UART_IDLE: if (fall)
                                state <= UART_START;
                        UART_START: if (mid) begin
                                state   <= rx ? UART_IDLE : UART_DATA;  // Glitch check
                                bit_cnt <= '0;
                        end
                        UART_DATA: if (mid) begin
                                if (bit_cnt == BW'(`UART_DATA_W - 1))
                                        state <= UART_STOP;
                                bit_cnt <= bit_cnt + 1'b1;
                        end
                        default: if (mid) begin
                                state <= UART_IDLE;
                                done  <= rx;    // Framing error drops the byte
                        end
                        endcase
                end
        end

        // LSB arrives first
        always_ff @(posedge clk) begin
                if (state == UART_DATA && mid)
                        data <= {rx, data[`UART_DATA_W-1:1]};
        end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module uart_tx
        import serial_pkg::*;
(
        input  logic                            clk,
        input  logic                            RSTn,
        input  logic                            start,
        input  logic [`UART_DATA_W-1:0]         data,
        output logic                            txd,
        output logic                            busy
);

        localparam int BW = $clog2(`UART_DATA_W);

        uart_state_e            state;
        logic [`UART_DATA_W-1:0] shreg;         // Remaining bits, LSB next
        logic [BW-1:0]          bit_cnt;
        logic                   tick;

        bit_timer #(.DIV(`UART_BIT_DIV)) i_bit_timer (
                .clk    (clk),
                .RSTn   (RSTn),
                .run    (busy),
                .tick   (tick),
                .mid    ()
        );

        assign busy = (state != UART_IDLE);

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state   <= UART_IDLE;
                        txd     <= 1'b1;        // Line idles high
                        bit_cnt <= '0;
                end else begin
                        case (state)
                        UART_IDLE: if (start) begin
                                state <= UART_START;
                                txd   <= 1'b0;  // Start bit
                        end
                        UART_START: if (tick) begin
                                state   <= UART_DATA;
                                txd     <= shreg[0];
                                bit_cnt <= '0;
                        end
                        UART_DATA: if (tick) begin
                                if (bit_cnt == BW'(`UART_DATA_W - 1)) begin
                                        state <= UART_STOP;
                                        txd   <= 1'b1;  // Stop bit
                                end else begin
                                        txd     <= shreg[1];
                                        bit_cnt <= bit_cnt + 1'b1;
                                end
                        end
                        default: if (tick)
                                state <= UART_IDLE;     // Stop bit done
                        endcase
                end
        end

        // Shift register, loaded on start and moved on each data bit
        always_ff @(posedge clk) begin
                if (state == UART_IDLE && start)
                        shreg <= data;
                else if (state == UART_DATA && tick)
                        shreg <= shreg >> 1;
        end

        a_txd_idle: assert property (@(posedge clk) disable iff (!RSTn)
                (state == UART_IDLE) |-> txd);

endmodule

`default_nettype wire

// File: verification/tb_serial_periph.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_defs.svh"

module tb_serial_periph
        import bus_pkg::*, serial_pkg::*;
();

        localparam int BIT_CYC      = `UART_BIT_DIV;
        localparam int FRAME_CYC    = 10 * `UART_BIT_DIV;      // Start, 8 data, stop
        localparam int N_TXN        = 3 * 20 + 4;               // Bytes, words and extras
        localparam int WATCHDOG_CYC = N_TXN * (FRAME_CYC + 40) + 1000;

        logic           clk = 1'b0;
        logic           RSTn;
        wb_req_t        wb_req;
        wb_rsp_t        wb_rsp;
        logic           rxd;
        logic           txd;
        logic           irq;
        logic           spi_cs;
        logic           spi_sclk;
        logic           spi_sdata;

        integer         seed;
        int             errors = 0;
        int             checks = 0;
        int             tx_frames = 0;          // Frames decoded on txd
        int             spi_frames = 0;         // Frames seen on the SPI lines

        logic [`UART_DATA_W-1:0] tx_exp[$];     // Bytes still due on txd
        logic [`SPI_DATA_W-1:0]  spi_exp[$];    // Words still due on SPI

        serial_periph i_serial_periph (
                .clk       (clk),
                .RSTn      (RSTn),
                .wb_req    (wb_req),
                .wb_rsp    (wb_rsp),
                .rxd       (rxd),
                .txd       (txd),
                .irq       (irq),
                .spi_cs    (spi_cs),
                .spi_sclk  (spi_sclk),
                .spi_sdata (spi_sdata)
        );

        always #4 clk = ~clk;   // 8 ns period

        // ----------------------------------------
        // Helpers
        // ----------------------------------------
        task automatic wait_cycles(input int n);
                repeat (n) @(posedge clk);
                #1;     // Back to the drive point
        endtask

        task automatic check_val(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("error %s got %h expected %h at %0t", name, got, exp, $time);
                end
        endtask

        task automatic note_failure(input string what);
                errors++;
                $display("%s at %0t", what, $time);
        endtask

        // One Wishbone classic access with the request held through the ack cycle
        task automatic bus_access(input logic we, input periph_reg_e adr,
                                  input logic [31:0] wdat, output logic [31:0] rdat);
                int n;
                n = 0;
                wb_req.cyc   = 1'b1;
                wb_req.stb   = 1'b1;
                wb_req.we    = we;
                wb_req.adr   = adr;
                wb_req.dat_w = wdat;
                wait_cycles(1);
                while (!wb_rsp.ack && n < 8) begin
                        wait_cycles(1);
                        n++;
                end
                if (!wb_rsp.ack)
                        note_failure("bus access got no ack");
                rdat = wb_rsp.dat_r;    // Valid in the ack cycle
                wait_cycles(1);         // Master still requesting while ack is sampled
                check_val("ack", 32'(wb_rsp.ack), 32'h0);      // Single cycle ack
                wb_req = '0;
                wait_cycles(1);         // Idle cycle between accesses
        endtask

        task automatic bus_write(input periph_reg_e adr, input logic [31:0] wdat);
                logic [31:0] unused;
                bus_access(1'b1, adr, wdat, unused);
        endtask

        task automatic bus_read(input periph_reg_e adr, output logic [31:0] rdat);
                bus_access(1'b0, adr, '0, rdat);
        endtask

        // Poll a status register until bit 0 clears
        task automatic wait_not_busy(input periph_reg_e adr);
                logic [31:0] rd;
                int n;
                n = 0;
                bus_read(adr, rd);
                while (rd[0] && n < 200) begin
                        bus_read(adr, rd);
                        n++;
                end
                if (rd[0])
                        note_failure("busy bit never cleared");
        endtask

        // Until both monitors have seen every expected frame
        task automatic wait_drained(input int limit);
                int n;
                n = 0;
                while ((tx_exp.size() != 0 || spi_exp.size() != 0) && n < limit) begin
                        wait_cycles(1);
                        n++;
                end
                if (tx_exp.size() != 0 || spi_exp.size() != 0)
                        note_failure("expected serial frames never appeared");
        endtask

        // UART serializer on rxd with LSB first
        task automatic send_rx_frame(input logic [7:0] b, input logic stop);
                rxd = 1'b0;
                wait_cycles(BIT_CYC);
                for (int i = 0; i < 8; i++) begin
                        rxd = b[i];
                        wait_cycles(BIT_CYC);
                end
                rxd = stop;     // Zero gives a framing error
                wait_cycles(BIT_CYC);
                rxd = 1'b1;
        endtask

        // ----------------------------------------
        // UART decoder on txd
        // ----------------------------------------
        initial begin : txd_decoder
                logic [7:0] b;
                forever begin
                        @(negedge txd);
                        repeat (BIT_CYC / 2) @(negedge clk);    // Middle of start bit
                        if (txd !== 1'b0)
                                note_failure("txd start bit not low at mid bit");
                        for (int i = 0; i < 8; i++) begin
                                repeat (BIT_CYC) @(negedge clk);
                                b[i] = txd;
                        end
                        repeat (BIT_CYC) @(negedge clk);
                        if (txd !== 1'b1)
                                note_failure("txd stop bit is low");
                        if (tx_exp.size() == 0)
                                note_failure("unexpected frame on txd");
                        else
                                check_val("txd", 32'(b), 32'(tx_exp.pop_front()));
                        tx_frames++;
                end
        end

        // ----------------------------------------
        // SPI edge monitor
        // ----------------------------------------
        initial begin : spi_monitor
                logic           cs_prev;
                logic           sclk_prev;
                logic [23:0]    w;
                int             edges;
                cs_prev   = 1'b1;
                sclk_prev = 1'b0;
                w         = '0;
                edges     = 0;
                forever begin
                        @(negedge clk);         // Lines settled after the rising clock
                        if (RSTn) begin
                                if (spi_cs && spi_sclk)
                                        note_failure("spi_sclk high while spi_cs is high");
                                if (!spi_cs && cs_prev) begin
                                        edges = 0;      // Frame opens
                                        w     = '0;
                                end
                                if (!spi_cs && spi_sclk && !sclk_prev) begin
                                        w = {w[22:0], spi_sdata};       // MSB first
                                        edges++;
                                end
                                if (spi_cs && !cs_prev) begin
                                        check_val("spi_sclk edges", edges, `SPI_DATA_W);
                                        if (spi_exp.size() == 0)
                                                note_failure("unexpected frame on spi");
                                        else
                                                check_val("spi_sdata", 32'(w),
                                                          32'(spi_exp.pop_front()));
                                        spi_frames++;
                                end
                                cs_prev   = spi_cs;
                                sclk_prev = spi_sclk;
                        end
                end
        end

        // ----------------------------------------
        // Watchdog
        // ----------------------------------------
        initial begin : watchdog
                repeat (WATCHDOG_CYC) @(posedge clk);
                $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYC);
                $display("CHECKS FAILED");
                $finish;
        end

        // ----------------------------------------
        // Stimulus
        // ----------------------------------------
        initial begin : stimulus
                logic [31:0]    rd;
                logic [7:0]     b;
                logic [23:0]    w;
                int             n;
                seed   = 32'hb561_cc9f;
                RSTn   = 1'b0;
                rxd    = 1'b1;          // Line idle
                wb_req = '0;
                repeat (4) @(posedge clk);
                #1;
                RSTn = 1'b1;
                wait_cycles(2);

                // State after reset
                check_val("txd", 32'(txd), 32'h1);
                check_val("spi_cs", 32'(spi_cs), 32'h1);
                check_val("spi_sclk", 32'(spi_sclk), 32'h0);
                check_val("irq", 32'(irq), 32'h0);
                check_val("ack", 32'(wb_rsp.ack), 32'h0);
                bus_read(REG_UART_STAT, rd);
                check_val("uart_stat", rd, 32'h0);
                bus_read(REG_SPI_STAT, rd);
                check_val("spi_stat", rd, 32'h0);

                // UART transmit
                for (int i = 0; i < 20; i++) begin
                        wait_not_busy(REG_UART_STAT);
                        b = 8'($random(seed));
                        tx_exp.push_back(b);
                        bus_write(REG_UART_DATA, 32'(b));
                end
                wait_drained(2 * FRAME_CYC);
                check_val("tx_frames", tx_frames, 20);

                // UART receive where a buffer read clears irq
                for (int i = 0; i < 20; i++) begin
                        b = 8'($random(seed));
                        send_rx_frame(b, 1'b1);
                        n = 0;
                        while (!irq && n < BIT_CYC) begin
                                wait_cycles(1);
                                n++;
                        end
                        if (!irq)
                                note_failure("irq did not rise after a received byte");
                        bus_read(REG_UART_STAT, rd);
                        check_val("uart_stat", rd, 32'h2);
                        bus_read(REG_UART_DATA, rd);
                        check_val("uart_data", rd, 32'(b));
                        check_val("irq", 32'(irq), 32'h0);
                end
                send_rx_frame(8'($random(seed)), 1'b0);        // Bad stop bit
                wait_cycles(2 * BIT_CYC);
                check_val("irq", 32'(irq), 32'h0);
                bus_read(REG_UART_STAT, rd);
                check_val("uart_stat", rd, 32'h0);

                // SPI words
                for (int i = 0; i < 20; i++) begin
                        wait_not_busy(REG_SPI_STAT);
                        w = 24'($random(seed));
                        spi_exp.push_back(w);
                        bus_write(REG_SPI_DATA, 32'(w));
                end
                wait_drained(2 * FRAME_CYC);
                check_val("spi_frames", spi_frames, 20);

                // Second writes while busy are dropped
                wait_not_busy(REG_UART_STAT);
                wait_not_busy(REG_SPI_STAT);
                b = 8'($random(seed));
                tx_exp.push_back(b);
                bus_write(REG_UART_DATA, 32'(b));
                bus_write(REG_UART_DATA, 32'(~b));
                w = 24'($random(seed));
                spi_exp.push_back(w);
                bus_write(REG_SPI_DATA, 32'(w));
                bus_write(REG_SPI_DATA, 32'(~w));
                wait_drained(2 * FRAME_CYC);
                wait_cycles(2 * FRAME_CYC);     // Room for a stray frame
                check_val("tx_frames", tx_frames, 21);
                check_val("spi_frames", spi_frames, 21);

                $display("errors %0d, checks %0d", errors, checks);
                if (errors == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

endmodule

`default_nettype wire
